//--- filelist.f
hdl/fetch_pkg.sv
hdl/icache_mem.sv
hdl/icache_ctrl.sv
hdl/fetch_stage.sv
hdl/fetch_buffer.sv
hdl/fetch_top.sv
tests/mem_model.sv
tests/fetch_tb.sv

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*; (
  input                                      clock,
  input                                      arst_n,
  input                                      flush,
  input        [1:0]                         push_cnt,
  input        [FETCH_WIDTH-1:0][ADDR_W-1:0] push_pc,
  input        [FETCH_WIDTH-1:0][INST_W-1:0] push_ir,
  input                                      inst_ready,
  output logic [FB_PTR_W:0]                  fb_free,
  output logic                               inst_valid,
  output logic [ADDR_W-1:0]                  inst_pc,
  output logic [INST_W-1:0]                  inst_ir
);

  logic [ADDR_W-1:0]   pc_q [FB_DEPTH];
  logic [INST_W-1:0]   ir_q [FB_DEPTH];
  logic [FB_PTR_W-1:0] head;
  logic [FB_PTR_W-1:0] tail;
  logic [FB_PTR_W:0]   count;
  logic                pop;

  assign inst_valid = (count != '0);
  assign inst_pc    = pc_q[head];
  assign inst_ir    = ir_q[head];
  assign pop        = inst_valid && inst_ready;
  assign fb_free    = (FB_PTR_W + 1)'(FB_DEPTH) - count;

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      tail  <= tail + FB_PTR_W'(push_cnt);
      count <= count + (FB_PTR_W + 1)'(push_cnt) - (FB_PTR_W + 1)'(pop);
    end
  end

  // Entries in PC order from the tail
  always_ff @(posedge clock) begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (i < push_cnt) begin
        pc_q[tail + FB_PTR_W'(i)] <= push_pc[i];
        ir_q[tail + FB_PTR_W'(i)] <= push_ir[i];
      end
    end
  end

  a_count_bound: assert property (
    @(posedge clock) disable iff (!arst_n)
    count <= (FB_PTR_W + 1)'(FB_DEPTH)
  );

  // Stage must respect the free count it was given
  a_push_fits: assert property (
    @(posedge clock) disable iff (!arst_n)
    (push_cnt != 2'd0) |-> ((FB_PTR_W + 1)'(push_cnt) <= fb_free)
  );

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

  // Datapath widths
  localparam int ADDR_W      = 64;
  localparam int INST_W      = 32;
  localparam int FETCH_WIDTH = 2;

  // Byte offset inside one 64-bit memory word
  localparam int OFFSET_W = 3;

  // Direct-mapped instruction cache geometry
  localparam int IDX_W     = 5;
  localparam int IDX_LO    = OFFSET_W;      // addr[7:3]
  localparam int NUM_LINES = 1 << IDX_W;
  localparam int TAG_W     = 8;
  localparam int TAG_LO    = IDX_LO + IDX_W; // addr[15:8]

  // Fetch buffer
  localparam int FB_DEPTH = 8;
  localparam int FB_PTR_W = 3;

  // Memory bus, tag zero means no transaction
  localparam int MEM_TAG_W = 4;

  localparam logic [1:0] BUS_NONE = 2'h0;
  localparam logic [1:0] BUS_LOAD = 2'h1;

  localparam logic [ADDR_W-1:0] RESET_PC = '0;

  // Miss handler states
  localparam logic [1:0] IC_IDLE = 2'd0;
  localparam logic [1:0] IC_REQ  = 2'd1;
  localparam logic [1:0] IC_WAIT = 2'd2;

  // One memory word, either raw or as two instructions.
  // Slot 0 sits in the low half, at the lower address.
  typedef union packed {
    logic [ADDR_W-1:0]                  raw;
    logic [FETCH_WIDTH-1:0][INST_W-1:0] slot;
  } fetch_word_u;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
  input                                          clock,
  input                                          arst_n,
  input                                          redirect_valid,
  input        [ADDR_W-1:0]                      redirect_pc,
  input  fetch_word_u                            rd_data,
  input                                          rd_hit,
  input        [FB_PTR_W:0]                      fb_free,
  output logic [ADDR_W-1:0]                      fetch_addr,
  output logic [IDX_W-1:0]                       rd_idx,
  output logic [TAG_W-1:0]                       rd_tag,
  output logic [1:0]                             push_cnt,
  output logic [FETCH_WIDTH-1:0][ADDR_W-1:0]     push_pc,
  output logic [FETCH_WIDTH-1:0][INST_W-1:0]     push_ir
);

  logic [ADDR_W-1:0]          pc;
  logic [ADDR_W-OFFSET_W-1:0] word_base;
  logic                       fetch_go;

  assign fetch_addr = pc;
  assign rd_idx     = pc[IDX_LO +: IDX_W];
  assign rd_tag     = pc[TAG_LO +: TAG_W];
  assign word_base  = pc[ADDR_W-1:OFFSET_W];

  // Room for a full word keeps the push logic simple
  assign fetch_go = rd_hit && !redirect_valid && (fb_free >= (FB_PTR_W + 1)'(FETCH_WIDTH));

  always_comb begin
    push_cnt   = 2'd0;
    push_pc[0] = pc;
    push_pc[1] = pc + ADDR_W'(4);
    push_ir[0] = rd_data.slot[pc[2]]; // first slot at or after the PC
    push_ir[1] = rd_data.slot[1];
    if (fetch_go) begin
      if (pc[2]) begin
        push_cnt = 2'd1;
      end else begin
        push_cnt = 2'd2;
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (redirect_valid) begin
      pc <= redirect_pc;
    end else if (fetch_go) begin
      // Next 8-byte boundary
      pc <= {word_base + 1'b1, {OFFSET_W{1'b0}}};
    end
  end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input                        clock,
  input                        arst_n,
  input        [MEM_TAG_W-1:0] mem2proc_response,
  input        [ADDR_W-1:0]    mem2proc_data,
  input        [MEM_TAG_W-1:0] mem2proc_tag,
  input                        redirect_valid,
  input        [ADDR_W-1:0]    redirect_pc,
  input                        inst_ready,
  output logic [1:0]           proc2mem_command,
  output logic [ADDR_W-1:0]    proc2mem_addr,
  output logic                 inst_valid,
  output logic [ADDR_W-1:0]    inst_pc,
  output logic [INST_W-1:0]    inst_ir
);

  // Cache lookup
  logic [IDX_W-1:0]  rd_idx;
  logic [TAG_W-1:0]  rd_tag;
  fetch_word_u       rd_data;
  logic              rd_hit;
  logic [ADDR_W-1:0] fetch_addr;

  // Line fill
  logic              wr_en;
  logic [IDX_W-1:0]  wr_idx;
  logic [TAG_W-1:0]  wr_tag;
  fetch_word_u       wr_data;

  logic [1:0]                         push_cnt;
  logic [FETCH_WIDTH-1:0][ADDR_W-1:0] push_pc;
  logic [FETCH_WIDTH-1:0][INST_W-1:0] push_ir;
  logic [FB_PTR_W:0]                  fb_free;

  icache_mem u_icache_mem (
    .clock   (clock),
    .arst_n  (arst_n),
    .rd_idx  (rd_idx),
    .rd_tag  (rd_tag),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_tag  (wr_tag),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .rd_hit  (rd_hit)
  );

  icache_ctrl u_icache_ctrl (
    .clock             (clock),
    .arst_n            (arst_n),
    .fetch_addr        (fetch_addr),
    .rd_hit            (rd_hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .wr_en             (wr_en),
    .wr_idx            (wr_idx),
    .wr_tag            (wr_tag),
    .wr_data           (wr_data)
  );

  fetch_stage u_fetch_stage (
    .clock          (clock),
    .arst_n         (arst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .rd_data        (rd_data),
    .rd_hit         (rd_hit),
    .fb_free        (fb_free),
    .fetch_addr     (fetch_addr),
    .rd_idx         (rd_idx),
    .rd_tag         (rd_tag),
    .push_cnt       (push_cnt),
    .push_pc        (push_pc),
    .push_ir        (push_ir)
  );

  // Redirect also empties the queue
  fetch_buffer u_fetch_buffer (
    .clock      (clock),
    .arst_n     (arst_n),
    .flush      (redirect_valid),
    .push_cnt   (push_cnt),
    .push_pc    (push_pc),
    .push_ir    (push_ir),
    .inst_ready (inst_ready),
    .fb_free    (fb_free),
    .inst_valid (inst_valid),
    .inst_pc    (inst_pc),
    .inst_ir    (inst_ir)
  );

endmodule

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import fetch_pkg::*; (
  input                        clock,
  input                        arst_n,
  input        [ADDR_W-1:0]    fetch_addr,
  input                        rd_hit,
  input        [MEM_TAG_W-1:0] mem2proc_response,
  input        [ADDR_W-1:0]    mem2proc_data,
  input        [MEM_TAG_W-1:0] mem2proc_tag,
  output logic [1:0]           proc2mem_command,
  output logic [ADDR_W-1:0]    proc2mem_addr,
  output logic                 wr_en,
  output logic [IDX_W-1:0]     wr_idx,
  output logic [TAG_W-1:0]     wr_tag,
  output fetch_word_u          wr_data
);

  logic [1:0]           state;
  logic [1:0]           state_n;
  logic [ADDR_W-1:0]    miss_addr;
  logic [MEM_TAG_W-1:0] mem_tag;
  logic                 accepted;
  logic                 fill;

  assign accepted = (state == IC_REQ) && (mem2proc_response != '0);
  assign fill     = (state == IC_WAIT) && (mem2proc_tag == mem_tag);

  always_comb begin
    state_n = state;
    case (state)
      IC_IDLE: begin
        if (!rd_hit) begin
          state_n = IC_REQ;
        end
      end
      IC_REQ: begin
        if (accepted) begin
          state_n = IC_WAIT;
        end
      end
      IC_WAIT: begin
        if (fill) begin
          state_n = IC_IDLE;
        end
      end
      default: state_n = IC_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IC_IDLE;
      miss_addr <= '0;
      mem_tag   <= '0;
    end else begin
      state <= state_n;
      if (state == IC_IDLE && !rd_hit) begin
        miss_addr <= {fetch_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}; // word aligned
      end
      if (accepted) begin
        mem_tag <= mem2proc_response;
      end else if (fill) begin
        mem_tag <= '0;
      end
    end
  end

  // Request held on the bus until a nonzero response
  assign proc2mem_command = (state == IC_REQ) ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = miss_addr;

  // Line write in the cycle the tag matches
  assign wr_en       = fill;
  assign wr_idx      = miss_addr[IDX_LO +: IDX_W];
  assign wr_tag      = miss_addr[TAG_LO +: TAG_W];
  assign wr_data.raw = mem2proc_data;

  // Rejected request must repeat unchanged
  a_req_held: assert property (
    @(posedge clock) disable iff (!arst_n)
    (proc2mem_command == BUS_LOAD && mem2proc_response == '0) |=>
      (proc2mem_command == BUS_LOAD && $stable(proc2mem_addr))
  );

  // One load outstanding at a time
  a_no_req_while_wait: assert property (
    @(posedge clock) disable iff (!arst_n)
    (state == IC_WAIT && !fill) |=> (proc2mem_command == BUS_NONE)
  );

endmodule

//--- hdl/icache_mem.sv
`timescale 1ns/1ps

module icache_mem import fetch_pkg::*; (
  input                      clock,
  input                      arst_n,
  input        [IDX_W-1:0]   rd_idx,
  input        [TAG_W-1:0]   rd_tag,
  input                      wr_en,
  input        [IDX_W-1:0]   wr_idx,
  input        [TAG_W-1:0]   wr_tag,
  input  fetch_word_u        wr_data,
  output fetch_word_u        rd_data,
  output logic               rd_hit
);

  logic [NUM_LINES-1:0] line_valid;
  logic [TAG_W-1:0]     line_tag  [NUM_LINES];
  fetch_word_u          line_data [NUM_LINES];

  // Only the valid bits need clearing
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      line_valid <= '0;
    end else if (wr_en) begin
      line_valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      line_tag[wr_idx]  <= wr_tag;
      line_data[wr_idx] <= wr_data;
    end
  end

  // Combinational lookup
  always_comb begin
    rd_data = line_data[rd_idx];
    rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
  end

  // A fill with a bad index would mark a random line valid
  a_wr_idx_known: assert property (
    @(posedge clock) disable iff (!arst_n)
    wr_en |-> !$isunknown(wr_idx)
  );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module fetch_tb -f filelist.f -o fetch_sim
out=$(./obj_dir/fetch_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q -x 'Testbench passed'; then
  exit 0
fi
exit 1

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam logic [INST_W-1:0] IR_KEY = 32'h5a3c_96e1;
  localparam int N_ROWS       = 5;
  localparam int QUIET_CYCLES = 12;  // longer than any gap between two loads

  logic                 clock;
  logic                 arst_n;
  logic [MEM_TAG_W-1:0] mem2proc_response;
  logic [ADDR_W-1:0]    mem2proc_data;
  logic [MEM_TAG_W-1:0] mem2proc_tag;
  logic                 redirect_valid;
  logic [ADDR_W-1:0]    redirect_pc;
  logic                 inst_ready;
  logic [1:0]           proc2mem_command;
  logic [ADDR_W-1:0]    proc2mem_addr;
  logic                 inst_valid;
  logic [ADDR_W-1:0]    inst_pc;
  logic [INST_W-1:0]    inst_ir;

  // Test name, start PC, instructions, ready %, range cached, PC of a load left in flight
  string       row_name   [N_ROWS] = '{"reset_run", "random_ready", "cached_refetch",
                                       "redirect_odd", "miss_redirect"};
  logic [63:0] row_pc     [N_ROWS] = '{64'h0, 64'h400, 64'h408, 64'h1004, 64'h5010};
  int          row_count  [N_ROWS] = '{40, 48, 16, 20, 24};
  int          row_ready  [N_ROWS] = '{100, 50, 60, 30, 70};
  bit          row_cached [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  logic [63:0] row_pre    [N_ROWS] = '{64'h0, 64'h0, 64'h0, 64'h0, 64'h3000};

  string             test_name;
  logic [ADDR_W-1:0] exp_pc;
  int                got;
  bit                watch_bus;
  int                idle_run;
  bit                saw_accept;
  int                cycle_cnt;
  int                cycle_limit;

  fetch_top u_dut (
    .clock             (clock),
    .arst_n            (arst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .redirect_valid    (redirect_valid),
    .redirect_pc       (redirect_pc),
    .inst_ready        (inst_ready),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .inst_valid        (inst_valid),
    .inst_pc           (inst_pc),
    .inst_ir           (inst_ir)
  );

  mem_model #(.IR_KEY(IR_KEY)) u_mem (
    .clock             (clock),
    .arst_n            (arst_n),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      stop_on_error($sformatf("timeout in %s after %0d cycles", test_name, cycle_cnt));
    end
  end

  task automatic check_reset_outputs();
    @(negedge clock);
    assert (inst_valid == 1'b0)
      else stop_on_error($sformatf("error %s: inst_valid expected 0 actual %b",
                                   test_name, inst_valid));
    assert (proc2mem_command == BUS_NONE)
      else stop_on_error($sformatf("error %s: command expected %h actual %h",
                                   test_name, BUS_NONE, proc2mem_command));
    @(posedge clock);
  endtask

  // Bus monitor and scoreboard, sampled mid cycle
  task automatic sample_outputs();
    if (proc2mem_command == BUS_LOAD) begin
      idle_run = 0;
      assert (proc2mem_addr[OFFSET_W-1:0] == '0)
        else stop_on_error($sformatf("error %s: load address low bits expected 0 actual %h",
                                     test_name, proc2mem_addr[OFFSET_W-1:0]));
    end else begin
      idle_run++;
    end
    if (proc2mem_command == BUS_LOAD && mem2proc_response != '0) begin
      saw_accept = 1'b1;
    end
    if (watch_bus) begin
      assert (proc2mem_command != BUS_LOAD)
        else stop_on_error($sformatf("%s: load issued at %h for a range already cached",
                                     test_name, proc2mem_addr));
    end
    if (inst_valid && inst_ready) begin
      assert (inst_pc == exp_pc)
        else stop_on_error($sformatf("error %s: pc expected %h actual %h",
                                     test_name, exp_pc, inst_pc));
      assert (inst_ir == (exp_pc[INST_W-1:0] ^ IR_KEY))
        else stop_on_error($sformatf("error %s: ir expected %h actual %h",
                                     test_name, exp_pc[INST_W-1:0] ^ IR_KEY, inst_ir));
      exp_pc = exp_pc + ADDR_W'(4);
      got++;
    end
  endtask

  task automatic tick(input logic ready_in, input logic redirect_in,
                      input logic [ADDR_W-1:0] pc_in);
    inst_ready     = ready_in;
    redirect_valid = redirect_in;
    redirect_pc    = pc_in;
    @(negedge clock);
    sample_outputs();
    @(posedge clock);
    #1;
  endtask

  initial begin
    void'($urandom(3));
    cycle_cnt   = 0;
    cycle_limit = 200;
    for (int r = 0; r < N_ROWS; r++) begin
      cycle_limit += 40 * row_count[r];
    end
    arst_n         = 1'b0;
    inst_ready     = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    exp_pc         = '0;
    got            = 0;
    watch_bus      = 1'b0;
    idle_run       = 0;
    saw_accept     = 1'b0;
    test_name      = "reset";
    @(posedge clock);
    repeat (4) check_reset_outputs();
    #1;
    arst_n    = 1'b1;
    test_name = "after_reset";
    check_reset_outputs();
    #1;
    for (int r = 0; r < N_ROWS; r++) begin
      test_name = row_name[r];
      if (r != 0) begin
        // Let the buffer fill and the bus go quiet before redirecting
        idle_run = 0;
        while (idle_run < QUIET_CYCLES) tick(1'b0, 1'b0, '0);
        if (row_pre[r] != '0) begin
          saw_accept = 1'b0;
          tick(1'b0, 1'b1, row_pre[r]);
          while (!saw_accept) tick(1'b0, 1'b0, '0);
        end
        tick(1'b0, 1'b1, row_pc[r]);
      end
      exp_pc    = row_pc[r];
      got       = 0;
      watch_bus = row_cached[r];
      while (got < row_count[r]) tick($urandom_range(99, 0) < row_ready[r], 1'b0, '0);
      watch_bus = 1'b0;
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model import fetch_pkg::*; #(
  parameter logic [INST_W-1:0] IR_KEY = '0
) (
  input                        clock,
  input                        arst_n,
  input        [1:0]           proc2mem_command,
  input        [ADDR_W-1:0]    proc2mem_addr,
  output logic [MEM_TAG_W-1:0] mem2proc_response,
  output logic [ADDR_W-1:0]    mem2proc_data,
  output logic [MEM_TAG_W-1:0] mem2proc_tag
);

  logic                 busy;
  int                   wait_cnt;
  logic [ADDR_W-1:0]    base;
  logic [MEM_TAG_W-1:0] tag;

  // Outputs move 1 ns after the rising edge
  initial begin
    mem2proc_response = '0;
    mem2proc_data     = '0;
    mem2proc_tag      = '0;
    busy              = 1'b0;
    wait_cnt          = 0;
    base              = '0;
    tag               = '0;
    forever begin
      @(posedge clock);
      #1;
      mem2proc_response = '0;
      mem2proc_data     = '0;
      mem2proc_tag      = '0;
      if (!arst_n) begin
        busy = 1'b0;
      end else if (busy) begin
        if (wait_cnt == 0) begin
          mem2proc_tag  = tag;
          // Slot at byte address a holds a[31:0] ^ IR_KEY
          mem2proc_data = {(base[INST_W-1:0] + 32'd4) ^ IR_KEY, base[INST_W-1:0] ^ IR_KEY};
          busy          = 1'b0;
        end else begin
          wait_cnt--;
        end
      end else if (proc2mem_command == BUS_LOAD && $urandom_range(1, 0) == 1) begin
        tag               = MEM_TAG_W'($urandom_range(15, 1));
        base              = {proc2mem_addr[ADDR_W-1:3], 3'b000};
        mem2proc_response = tag;               // accept with this tag
        wait_cnt          = int'($urandom_range(6, 2)) - 1;
        busy              = 1'b1;
      end
    end
  end

endmodule
